// ==== rms_norm_testdata.hex ====
// in0 in1 in2 in3 exp0 exp1 exp2 exp3, signed bytes, one 2x2 beat per line
// Tensor 1 mixed signs, mean square 74, inverse root 7
0A F9 03 F4 11 F3 05 EB
05 0E F7 00 08 18 F0 00
FD 08 0B FA FA 0E 13 F5
0D FF 07 F6 16 FE 0C EE
02 F2 09 06 03 E7 0F 0A
F5 04 FB 0C EC 07 F7 15
01 F8 0F FE 01 F2 1A FC
F3 09 FC 07 E9 0F F9 0C
// Tensor 2 all zeros
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
// Tensor 3 sparse, mean square floors to 0 so nonzero lanes saturate
03 FD 00 00 7F 80 00 00
00 02 00 FE 00 7F 00 80
01 00 00 00 7F 00 00 00
00 00 FF 00 00 00 80 00
00 00 00 00 00 00 00 00
01 00 00 FF 7F 00 00 80
00 00 00 00 00 00 00 00
00 00 00 01 00 00 00 7F

// ==== rms_norm.f ====
+incdir+.
rms_norm_pkg.sv
skid_buffer.sv
matrix_fifo.sv
fixed_adder_tree.sv
fixed_accumulator.sv
fixed_isqrt.sv
repeat_buffer.sv
rms_norm_2d.sv
tb_rms_norm_2d.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RMS normalization testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rms_norm_2d -f rms_norm.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// ==== tb_rms_norm_2d.sv ====
/*
 * Testbench for the RMS normalization top level
 * Streams three tensors from the test data file back to back, applies
 * random output back-pressure and compares every output beat in order.
 */
`timescale 1ns/1ps
`include "rms_norm_macros.svh"

module tb_rms_norm_2d;
    import rms_norm_pkg::*;

    localparam int LANES          = `RMS_LANES;
    localparam int NUM_BEATS      = 3 * `RMS_NUM_ITERS;
    localparam int BEAT_WORDS     = 2 * LANES;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int IDLE_CYCLES    = 40;
    localparam logic [31:0] RNG_SEED = 32'd14;
    localparam string DATA_FILE   = "rms_norm_testdata.hex";

    logic      clk;
    logic      rst_n;
    in_elem_t  in_data [LANES];
    logic      in_valid;
    logic      in_ready;
    out_elem_t out_data [LANES];
    logic      out_valid;
    logic      out_ready;

    // Input lanes then expected lanes, one beat per row
    logic [7:0] test_vectors [NUM_BEATS * BEAT_WORDS];
    int         accepted;

    rms_norm_2d rms_norm_2d_inst (
        .clk(clk),
        .rst_n(rst_n),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] state);
        logic [31:0] v;
        v = state;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic fail_with(string reason);
        $display("ERROR: %s", reason);
        abort_run();
    endtask

    task automatic check_value(string name, logic [7:0] expected, logic [7:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic wait_input_accept(int beat);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_with($sformatf("input beat %0d was never accepted", beat));
            end
        end while (!in_ready);
    endtask

    task automatic drive_inputs();
        for (int b = 0; b < NUM_BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                in_data[l] <= in_elem_t'(test_vectors[b * BEAT_WORDS + l]);
            end
            in_valid <= 1'b1;
            wait_input_accept(b);
        end
        in_valid <= 1'b0;
    endtask

    task automatic collect_outputs();
        int cycles;
        int needed;
        for (int b = 0; b < NUM_BEATS; b++) begin
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                if (cycles > TIMEOUT_CYCLES) begin
                    fail_with($sformatf("output beat %0d did not arrive", b));
                end
            end while (!(out_valid && out_ready));
            // A tensor's first output needs all 8 of its input beats
            if (b % `RMS_NUM_ITERS == 0) begin
                needed = (b / `RMS_NUM_ITERS + 1) * `RMS_NUM_ITERS;
                if (accepted < needed) begin
                    fail_with($sformatf("output beat %0d came before its tensor was complete", b));
                end
            end
            for (int l = 0; l < LANES; l++) begin
                check_value($sformatf("out_data[%0d] of beat %0d", l, b),
                            test_vectors[b * BEAT_WORDS + LANES + l], out_data[l]);
            end
        end
    endtask

    task automatic check_no_extra_output();
        for (int c = 0; c < IDLE_CYCLES; c++) begin
            @(posedge clk);
            if (out_valid) begin
                fail_with("an extra output beat appeared after the last tensor");
            end
        end
    endtask

    // Count of input transfers, seen at each edge
    always @(posedge clk) begin
        if (!rst_n) begin
            accepted <= 0;
        end else if (in_valid && in_ready) begin
            accepted <= accepted + 1;
        end
    end

    // Output back-pressure, ready about 3 cycles in 4
    initial begin
        logic [31:0] rng_state;
        rng_state = RNG_SEED;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            rng_state = xorshift32(rng_state);
            out_ready <= rst_n && (rng_state[1:0] != 2'b00);
        end
    end

    initial begin
        int fd;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            in_data[l] = '0;
        end

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            fail_with("the test data file could not be opened");
        end else begin
            $fclose(fd);
        end
        $readmemh(DATA_FILE, test_vectors);

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("out_valid after reset", 8'h00, {7'b0, out_valid});

        fork
            drive_inputs();
            collect_outputs();
        join
        check_no_extra_output();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== rms_norm_2d.sv ====
/*
 * RMS normalization, 2D top level
 * Squares and sums each tensor, derives the inverse root of the mean
 * square, then scales the buffered input beats by it. Output is signed
 * 8 bits with 4 fraction bits, floored and saturated.
 */
`timescale 1ns/1ps
`include "rms_norm_macros.svh"

module rms_norm_2d (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rms_norm_pkg::in_elem_t  in_data [`RMS_LANES],
    input  logic                   in_valid,
    output logic                   in_ready,
    output rms_norm_pkg::out_elem_t out_data [`RMS_LANES],
    output logic                   out_valid,
    input  logic                   out_ready
);
    import rms_norm_pkg::*;

    localparam int LANES      = `RMS_LANES;
    localparam int CAST_SHIFT = `RMS_IN_FRAC + `RMS_ISQRT_FRAC - `RMS_OUT_FRAC;
    localparam norm_t OUT_MAX = norm_t'((1 << (`RMS_OUT_WIDTH - 1)) - 1);
    localparam norm_t OUT_MIN = -norm_t'(1 << (`RMS_OUT_WIDTH - 1));

    in_elem_t   fifo_data [LANES];
    logic       fifo_in_valid, fifo_in_ready, fifo_out_valid, fifo_out_ready;
    square_t    sq_in [LANES];
    square_t    sq_out [LANES];
    logic       sq_in_valid, sq_out_ready;
    logic [LANES-1:0] sq_in_ready, sq_out_valid;
    lane_sum_t  tree_data;
    logic       tree_valid, tree_ready;
    acc_t       acc_data, mean_in, mean_out;
    logic       acc_valid, acc_ready, mean_valid, mean_ready;
    isqrt_t     clamp_in, clamp_out, root_data, rep_data;
    logic       clamp_valid, clamp_ready, root_valid, root_ready, rep_valid, rep_ready;
    norm_t      mul_in [LANES];
    norm_t      mul_out [LANES];
    out_elem_t  cast_in [LANES];
    logic       mul_in_valid;
    logic [LANES-1:0] mul_in_ready, mul_out_valid, mul_out_ready, cast_valid;

    // Input split, lane 0 stands for all square lanes
    assign in_ready      = fifo_in_ready & sq_in_ready[0];
    assign fifo_in_valid = in_valid & sq_in_ready[0];
    assign sq_in_valid   = in_valid & fifo_in_ready;

    matrix_fifo input_fifo_inst (
        .clk(clk), .rst_n(rst_n),
        .in_data(in_data), .in_valid(fifo_in_valid), .in_ready(fifo_in_ready),
        .out_data(fifo_data), .out_valid(fifo_out_valid), .out_ready(fifo_out_ready)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_square
        assign sq_in[i] = in_data[i] * in_data[i];

        skid_buffer #(.DATA_WIDTH(SQUARE_W)) square_reg (
            .clk(clk), .rst_n(rst_n),
            .data_in(sq_in[i]), .data_in_valid(sq_in_valid), .data_in_ready(sq_in_ready[i]),
            .data_out(sq_out[i]), .data_out_valid(sq_out_valid[i]),
            .data_out_ready(sq_out_ready)
        );
    end

    fixed_adder_tree adder_tree_inst (
        .clk(clk), .rst_n(rst_n),
        .data_in(sq_out), .data_in_valid(sq_out_valid[0]), .data_in_ready(sq_out_ready),
        .data_out(tree_data), .data_out_valid(tree_valid), .data_out_ready(tree_ready)
    );

    fixed_accumulator accumulator_inst (
        .clk(clk), .rst_n(rst_n),
        .data_in(tree_data), .data_in_valid(tree_valid), .data_in_ready(tree_ready),
        .data_out(acc_data), .data_out_valid(acc_valid), .data_out_ready(acc_ready)
    );

    // Mean over 32 values is an exact shift
    assign mean_in = acc_data >> `RMS_NUM_SHIFT;

    skid_buffer #(.DATA_WIDTH(ACC_W)) mean_reg (
        .clk(clk), .rst_n(rst_n),
        .data_in(mean_in), .data_in_valid(acc_valid), .data_in_ready(acc_ready),
        .data_out(mean_out), .data_out_valid(mean_valid), .data_out_ready(mean_ready)
    );

    assign clamp_in = (|mean_out[ACC_W-1:`RMS_ISQRT_WIDTH]) ? '1
                                                            : mean_out[`RMS_ISQRT_WIDTH-1:0];

    skid_buffer #(.DATA_WIDTH(`RMS_ISQRT_WIDTH)) clamp_reg (
        .clk(clk), .rst_n(rst_n),
        .data_in(clamp_in), .data_in_valid(mean_valid), .data_in_ready(mean_ready),
        .data_out(clamp_out), .data_out_valid(clamp_valid), .data_out_ready(clamp_ready)
    );

    fixed_isqrt isqrt_inst (
        .clk(clk), .rst_n(rst_n),
        .in_data(clamp_out), .in_valid(clamp_valid), .in_ready(clamp_ready),
        .out_data(root_data), .out_valid(root_valid), .out_ready(root_ready)
    );

    repeat_buffer repeat_inst (
        .clk(clk), .rst_n(rst_n),
        .in_data(root_data), .in_valid(root_valid), .in_ready(root_ready),
        .out_data(rep_data), .out_valid(rep_valid), .out_ready(rep_ready)
    );

    // Join of buffered beats and their inverse root
    assign mul_in_valid   = fifo_out_valid & rep_valid;
    assign fifo_out_ready = mul_in_ready[0] & rep_valid;
    assign rep_ready      = mul_in_ready[0] & fifo_out_valid;

    for (genvar i = 0; i < LANES; i++) begin : g_mult_cast
        norm_t shifted;

        assign mul_in[i] = $signed({1'b0, rep_data}) * fifo_data[i];

        skid_buffer #(.DATA_WIDTH(NORM_W)) norm_reg (
            .clk(clk), .rst_n(rst_n),
            .data_in(mul_in[i]), .data_in_valid(mul_in_valid),
            .data_in_ready(mul_in_ready[i]),
            .data_out(mul_out[i]), .data_out_valid(mul_out_valid[i]),
            .data_out_ready(mul_out_ready[i])
        );

        // Floor by dropping 2 fraction bits, then saturate
        assign shifted    = mul_out[i] >>> CAST_SHIFT;
        assign cast_in[i] = (shifted > OUT_MAX) ? out_elem_t'(OUT_MAX) :
                            (shifted < OUT_MIN) ? out_elem_t'(OUT_MIN) :
                                                  out_elem_t'(shifted);

        skid_buffer #(.DATA_WIDTH(`RMS_OUT_WIDTH)) output_reg (
            .clk(clk), .rst_n(rst_n),
            .data_in(cast_in[i]), .data_in_valid(mul_out_valid[i]),
            .data_in_ready(mul_out_ready[i]),
            .data_out(out_data[i]), .data_out_valid(cast_valid[i]),
            .data_out_ready(out_ready)
        );
    end

    assign out_valid = cast_valid[0];

endmodule

// ==== repeat_buffer.sv ====
/*
 * Repeat buffer
 * Holds one value and presents it for 8 output transfers
 */
`timescale 1ns/1ps
`include "rms_norm_macros.svh"

module repeat_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  rms_norm_pkg::isqrt_t in_data,
    input  logic                in_valid,
    output logic                in_ready,
    output rms_norm_pkg::isqrt_t out_data,
    output logic                out_valid,
    input  logic                out_ready
);

    localparam int CW = $clog2(`RMS_NUM_ITERS);

    logic [CW-1:0] sent;

    assign in_ready = ~out_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            sent      <= '0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
            sent      <= '0;
        end else if (out_valid && out_ready) begin
            sent <= sent + 1'b1;
            if (sent == CW'(`RMS_NUM_ITERS - 1)) out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) out_data <= in_data;
    end

endmodule

// ==== fixed_isqrt.sv ====
/*
 * Fixed-point inverse square root
 * Bit-by-bit search from the MSB down for the largest y with
 * y*y*x <= 1.0, all values with 4 fraction bits. x = 0 gives all ones.
 */
`timescale 1ns/1ps
`include "rms_norm_macros.svh"

module fixed_isqrt (
    input  logic                clk,
    input  logic                rst_n,
    input  rms_norm_pkg::isqrt_t in_data,
    input  logic                in_valid,
    output logic                in_ready,
    output rms_norm_pkg::isqrt_t out_data,
    output logic                out_valid,
    input  logic                out_ready
);
    import rms_norm_pkg::*;

    localparam int W  = `RMS_ISQRT_WIDTH;
    localparam int BW = $clog2(W);
    localparam int SW = $clog2(W + 1);
    // 1.0 with three factors of 4 fraction bits each, 4096
    localparam logic [3*W-1:0] ONE_Q = (3*W)'(1) << (3 * `RMS_ISQRT_FRAC);

    isqrt_t          x, y, trial;
    logic [3*W-1:0]  prod;
    logic [SW-1:0]   step;
    logic [BW-1:0]   bit_pos;
    logic            busy;

    assign in_ready = ~busy & ~out_valid;
    assign bit_pos  = BW'(W - 1) - BW'(step);
    assign trial    = y | (isqrt_t'(1) << bit_pos);
    assign prod     = trial * trial * x;
    assign out_data = y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            step      <= '0;
        end else if (in_valid && in_ready) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            // One test per cycle, then a cycle to raise out_valid
            if (step == SW'(W)) begin
                busy      <= 1'b0;
                out_valid <= 1'b1;
            end else begin
                step <= step + 1'b1;
            end
        end else if (out_valid && out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            x <= in_data;
            y <= '0;
        end else if (busy && step != SW'(W) && prod <= ONE_Q) begin
            y <= trial;
        end
    end

endmodule

// ==== fixed_accumulator.sv ====
/*
 * Fixed-point accumulator
 * Adds 8 lane sums and presents one total per tensor, holding off
 * new input until the total is taken
 */
`timescale 1ns/1ps
`include "rms_norm_macros.svh"

module fixed_accumulator (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rms_norm_pkg::lane_sum_t data_in,
    input  logic                   data_in_valid,
    output logic                   data_in_ready,
    output rms_norm_pkg::acc_t      data_out,
    output logic                   data_out_valid,
    input  logic                   data_out_ready
);
    import rms_norm_pkg::*;

    localparam int IW = $clog2(`RMS_NUM_ITERS);

    logic [IW-1:0] beat;
    acc_t          sum;
    logic          take;

    assign data_in_ready = ~data_out_valid;
    assign take          = data_in_valid & data_in_ready;
    assign data_out      = sum;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat           <= '0;
            data_out_valid <= 1'b0;
        end else begin
            if (take) begin
                beat <= (beat == IW'(`RMS_NUM_ITERS - 1)) ? '0 : beat + 1'b1;
                if (beat == IW'(`RMS_NUM_ITERS - 1)) data_out_valid <= 1'b1;
            end
            if (data_out_valid && data_out_ready) data_out_valid <= 1'b0;
        end
    end

    // First beat of a tensor restarts the sum
    always_ff @(posedge clk) begin
        if (take) sum <= (beat == '0) ? acc_t'(data_in) : sum + acc_t'(data_in);
    end

endmodule

// ==== fixed_adder_tree.sv ====
/*
 * Fixed-point adder tree
 * Sums the 4 lane squares in two levels into one registered result
 */
`timescale 1ns/1ps
`include "rms_norm_macros.svh"

module fixed_adder_tree (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rms_norm_pkg::square_t   data_in [`RMS_LANES],
    input  logic                   data_in_valid,
    output logic                   data_in_ready,
    output rms_norm_pkg::lane_sum_t data_out,
    output logic                   data_out_valid,
    input  logic                   data_out_ready
);
    import rms_norm_pkg::*;

    logic [SQUARE_W:0] sum_lo, sum_hi;

    assign sum_lo        = data_in[0] + data_in[1];
    assign sum_hi        = data_in[2] + data_in[3];
    assign data_in_ready = ~data_out_valid | data_out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out_valid <= 1'b0;
        end else if (data_in_ready) begin
            data_out_valid <= data_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (data_in_ready && data_in_valid) data_out <= sum_lo + sum_hi;
    end

endmodule

// ==== matrix_fifo.sv ====
/*
 * Matrix FIFO
 * Circular buffer of 4-lane input beats with a registered output.
 * An empty buffer passes a beat straight to the output register.
 */
`timescale 1ns/1ps
`include "rms_norm_macros.svh"

module matrix_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rms_norm_pkg::in_elem_t in_data [`RMS_LANES],
    input  logic                  in_valid,
    output logic                  in_ready,
    output rms_norm_pkg::in_elem_t out_data [`RMS_LANES],
    output logic                  out_valid,
    input  logic                  out_ready
);
    import rms_norm_pkg::*;

    localparam int DEPTH = `RMS_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    in_elem_t       mem [DEPTH][`RMS_LANES];
    logic [PW-1:0]  wptr, rptr;
    logic [CW-1:0]  count;
    logic           push, out_load, bypass, mem_push, mem_pop;

    assign in_ready = (count != CW'(DEPTH));
    assign push     = in_valid & in_ready;
    assign out_load = out_ready | ~out_valid;
    assign mem_pop  = out_load & (count != '0);
    assign bypass   = push & out_load & (count == '0);
    assign mem_push = push & ~bypass;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr      <= '0;
            rptr      <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_push) wptr <= wptr + 1'b1;
            if (mem_pop) rptr <= rptr + 1'b1;
            count <= count + CW'(mem_push) - CW'(mem_pop);
            if (out_load) out_valid <= mem_pop | bypass;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_push) mem[wptr] <= in_data;
        if (mem_pop) begin
            out_data <= mem[rptr];
        end else if (bypass) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== skid_buffer.sv ====
/*
 * Skid buffer
 * Two-entry valid/ready register stage. The input ready is registered,
 * and the skid entry absorbs the beat in flight when the output stalls.
 */
`timescale 1ns/1ps

module skid_buffer #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic                  data_in_valid,
    output logic                  data_in_ready,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  data_out_valid,
    input  logic                  data_out_ready
);

    logic [DATA_WIDTH-1:0] skid_data;
    logic                  skid_valid;
    logic                  load_out;

    // Main register may take a new beat
    assign load_out      = data_out_ready | ~data_out_valid;
    assign data_in_ready = ~skid_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out_valid <= 1'b0;
            skid_valid     <= 1'b0;
        end else if (load_out) begin
            data_out_valid <= skid_valid | data_in_valid;
            skid_valid     <= 1'b0;
        end else if (data_in_valid && !skid_valid) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            data_out <= skid_valid ? skid_data : data_in;
        end else if (data_in_valid && !skid_valid) begin
            skid_data <= data_in;
        end
    end

endmodule

// ==== rms_norm_pkg.sv ====
/*
 * RMS normalization types
 * Element types for each stage of the fixed-point datapath
 */
`include "rms_norm_macros.svh"

package rms_norm_pkg;

    localparam int SQUARE_W   = 2 * `RMS_IN_WIDTH;
    localparam int LANE_SUM_W = SQUARE_W + $clog2(`RMS_LANES);
    localparam int ACC_W      = LANE_SUM_W + $clog2(`RMS_NUM_ITERS);
    localparam int NORM_W     = `RMS_ISQRT_WIDTH + `RMS_IN_WIDTH;

    typedef logic signed [`RMS_IN_WIDTH-1:0]  in_elem_t;
    // Squares carry 4 fraction bits
    typedef logic        [SQUARE_W-1:0]       square_t;
    typedef logic        [LANE_SUM_W-1:0]     lane_sum_t;
    typedef logic        [ACC_W-1:0]          acc_t;
    // Mean square and inverse root share one format
    typedef logic        [`RMS_ISQRT_WIDTH-1:0] isqrt_t;
    typedef logic signed [NORM_W-1:0]         norm_t;
    typedef logic signed [`RMS_OUT_WIDTH-1:0] out_elem_t;

endpackage

// ==== rms_norm_macros.svh ====
/*
 * RMS normalization dimensions and widths
 * Tensor is 2 channels of 4x4, streamed as 8 beats of 2x2 lanes
 */
`ifndef RMS_NORM_MACROS_SVH
`define RMS_NORM_MACROS_SVH

// Compute block of one beat
`define RMS_COMPUTE_DIM0 2
`define RMS_COMPUTE_DIM1 2
`define RMS_LANES (`RMS_COMPUTE_DIM0 * `RMS_COMPUTE_DIM1)

// Beats per tensor and log2 of values per tensor (32)
`define RMS_NUM_ITERS 8
`define RMS_NUM_SHIFT 5

// Fixed-point formats
`define RMS_IN_WIDTH 8
`define RMS_IN_FRAC 2
`define RMS_ISQRT_WIDTH 16
`define RMS_ISQRT_FRAC 4
`define RMS_OUT_WIDTH 8
`define RMS_OUT_FRAC 4

`define RMS_FIFO_DEPTH 16

`endif
